//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= stq_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "All tests passed" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
source/stq_pkg.sv
source/stq_ring_ctrl.sv
source/stq_entry_array.sv
source/stq_fwd_check.sv
source/stq_drain.sv
source/stq_top.sv
test/stq_checker.sv
test/stq_tb.sv

//--- source/stq_drain.sv
`timescale 1ns/1ps

module stq_drain #(
  parameter int STQ_DEPTH = 8
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic [$clog2(STQ_DEPTH)-1:0] i_head_idx,
  input  stq_pkg::entry_state_e        i_state [STQ_DEPTH],
  input  stq_pkg::paddr_t              i_paddr [STQ_DEPTH],
  input  stq_pkg::mem_size_e           i_size  [STQ_DEPTH],
  input  stq_pkg::data_t               i_data  [STQ_DEPTH],

  input  logic                         i_sb_ready,

  output logic                         o_release,
  output logic                         o_sb_valid,
  output stq_pkg::paddr_t              o_sb_paddr,
  output stq_pkg::strb_t               o_sb_strb,
  output stq_pkg::data_t               o_sb_data
);

  import stq_pkg::*;

  localparam int OFF_W = $clog2(STRB_W);

  logic             w_load;
  paddr_t           w_head_paddr;
  logic [OFF_W-1:0] w_head_off;

  assign w_head_paddr = i_paddr[i_head_idx];
  assign w_head_off   = w_head_paddr[OFF_W-1:0];

  // Register empty and head committed
  assign w_load    = ~o_sb_valid & (i_state[i_head_idx] == ST_COMMITTED);
  assign o_release = o_sb_valid & i_sb_ready;

  // ==================================================
  // Request register
  // ==================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_sb_valid <= 1'b0;
    end else if (w_load) begin
      o_sb_valid <= 1'b1;
    end else if (o_release) begin
      o_sb_valid <= 1'b0;   // Empty for one cycle before the next head
    end
  end

  // Held while the store buffer stalls
  always_ff @(posedge i_clk) begin
    if (w_load) begin
      o_sb_paddr <= {w_head_paddr[PADDR_W-1:OFF_W], {OFF_W{1'b0}}};
      o_sb_strb  <= size_strb(i_size[i_head_idx]) << w_head_off;
      o_sb_data  <= i_data[i_head_idx] << {w_head_off, 3'b000};
    end
  end

endmodule

//--- source/stq_entry_array.sv
`timescale 1ns/1ps

module stq_entry_array #(
  parameter int STQ_DEPTH = 8
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  // Allocation at the tail
  input  logic                         i_alloc_fire,
  input  logic [$clog2(STQ_DEPTH)-1:0] i_tail_idx,

  // Commit in order
  input  logic                         i_commit_valid,
  input  logic [$clog2(STQ_DEPTH)-1:0] i_commit_idx,

  // Release from the drain stage
  input  logic                         i_release,
  input  logic [$clog2(STQ_DEPTH)-1:0] i_head_idx,

  // Address and data fill
  input  logic                         i_upd_valid,
  input  logic [$clog2(STQ_DEPTH)-1:0] i_upd_idx,
  input  stq_pkg::paddr_t              i_upd_paddr,
  input  stq_pkg::mem_size_e           i_upd_size,
  input  stq_pkg::data_t               i_upd_data,

  output stq_pkg::entry_state_e        o_state [STQ_DEPTH],
  output stq_pkg::paddr_t              o_paddr [STQ_DEPTH],
  output stq_pkg::mem_size_e           o_size  [STQ_DEPTH],
  output stq_pkg::data_t               o_data  [STQ_DEPTH]
);

  import stq_pkg::*;

  localparam int IDX_W = $clog2(STQ_DEPTH);

  for (genvar s = 0; s < STQ_DEPTH; s++) begin : g_entry
    entry_state_e r_state;
    paddr_t       r_paddr;
    mem_size_e    r_size;
    data_t        r_data;
    logic         w_alloc;
    logic         w_upd;
    logic         w_commit;
    logic         w_release;

    // ==================================================
    // Event decode for this slot
    // ==================================================
    assign w_alloc   = i_alloc_fire & (i_tail_idx == IDX_W'(s));
    assign w_upd     = i_upd_valid & (i_upd_idx == IDX_W'(s)) &
                       (r_state == ST_WAIT_ADDR);
    assign w_commit  = i_commit_valid & (i_commit_idx == IDX_W'(s));
    assign w_release = i_release & (i_head_idx == IDX_W'(s));

    // Entry FSM
    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_state <= ST_FREE;
      end else begin
        case (r_state)
          ST_FREE: begin
            if (w_alloc) begin
              r_state <= ST_WAIT_ADDR;
            end
          end
          ST_WAIT_ADDR: begin
            if (w_upd) begin
              r_state <= ST_READY;
            end
          end
          ST_READY: begin
            if (w_commit) begin
              r_state <= ST_COMMITTED;
            end
          end
          ST_COMMITTED: begin
            if (w_release) begin   // Store buffer took it
              r_state <= ST_FREE;
            end
          end
          default: r_state <= ST_FREE;
        endcase
      end
    end

    // Payload
    always_ff @(posedge i_clk) begin
      if (w_upd) begin
        r_paddr <= i_upd_paddr;
        r_size  <= i_upd_size;
        r_data  <= i_upd_data;
      end
    end

    assign o_state[s] = r_state;
    assign o_paddr[s] = r_paddr;
    assign o_size[s]  = r_size;
    assign o_data[s]  = r_data;
  end

endmodule

//--- source/stq_fwd_check.sv
`timescale 1ns/1ps

module stq_fwd_check #(
  parameter int STQ_DEPTH = 8
) (
  input  logic                         i_ld_valid,
  input  stq_pkg::paddr_t              i_ld_paddr,
  input  stq_pkg::mem_size_e           i_ld_size,
  input  logic [$clog2(STQ_DEPTH)-1:0] i_ld_age_idx,
  input  logic [$clog2(STQ_DEPTH)-1:0] i_head_idx,

  input  stq_pkg::entry_state_e        i_state [STQ_DEPTH],
  input  stq_pkg::paddr_t              i_paddr [STQ_DEPTH],
  input  stq_pkg::mem_size_e           i_size  [STQ_DEPTH],
  input  stq_pkg::data_t               i_data  [STQ_DEPTH],

  output logic                         o_fwd_valid,
  output stq_pkg::strb_t               o_fwd_strb,
  output stq_pkg::data_t               o_fwd_data
);

  import stq_pkg::*;

  localparam int IDX_W = $clog2(STQ_DEPTH);
  localparam int OFF_W = $clog2(STRB_W);

  logic [IDX_W-1:0]     w_age_rel;    // Number of stores older than the load
  strb_t                w_ld_strb;
  logic [STQ_DEPTH-1:0] w_cand;
  strb_t                w_ent_strb [STQ_DEPTH];
  data_t                w_ent_data [STQ_DEPTH];

  assign w_age_rel = i_ld_age_idx - i_head_idx;
  assign w_ld_strb = size_strb(i_ld_size) << i_ld_paddr[OFF_W-1:0];

  for (genvar s = 0; s < STQ_DEPTH; s++) begin : g_entry
    logic [IDX_W-1:0] w_rel;
    logic             w_has_addr;
    logic             w_same_dw;

    assign w_rel      = IDX_W'(s) - i_head_idx;   // Age from the head
    assign w_has_addr = (i_state[s] == ST_READY) | (i_state[s] == ST_COMMITTED);
    assign w_same_dw  = (i_paddr[s][PADDR_W-1:OFF_W] == i_ld_paddr[PADDR_W-1:OFF_W]);

    assign w_cand[s]     = i_ld_valid & w_has_addr & w_same_dw & (w_rel < w_age_rel);
    assign w_ent_strb[s] = (size_strb(i_size[s]) << i_paddr[s][OFF_W-1:0]) & w_ld_strb;
    assign w_ent_data[s] = i_data[s] << {i_paddr[s][OFF_W-1:0], 3'b000};
  end

  // ==================================================
  // Per-lane pick of the youngest older store
  // ==================================================
  // Walk oldest to youngest so the last hit in a lane wins
  always_comb begin
    logic [IDX_W-1:0] idx;
    idx        = '0;
    o_fwd_strb = '0;
    o_fwd_data = '0;
    for (int b = 0; b < STRB_W; b++) begin
      for (int k = 0; k < STQ_DEPTH; k++) begin
        idx = i_head_idx + IDX_W'(k);
        if (w_cand[idx] && w_ent_strb[idx][b]) begin
          o_fwd_strb[b]        = 1'b1;
          o_fwd_data[b*8 +: 8] = w_ent_data[idx][b*8 +: 8];
        end
      end
    end
  end

  assign o_fwd_valid = |o_fwd_strb;

endmodule

//--- source/stq_pkg.sv
package stq_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int PADDR_W = 32;
  localparam int DATA_W  = 64;
  localparam int STRB_W  = DATA_W / 8;   // Byte lanes per doubleword

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [STRB_W-1:0]  strb_t;

  // ==================================================
  // Encodings
  // ==================================================
  typedef enum logic [1:0] {
    MEM_B = 2'd0,   // 1 byte
    MEM_H = 2'd1,   // 2 bytes
    MEM_W = 2'd2,   // 4 bytes
    MEM_D = 2'd3    // 8 bytes
  } mem_size_e;

  typedef enum logic [1:0] {
    ST_FREE      = 2'd0,
    ST_WAIT_ADDR = 2'd1,   // Allocated, no address yet
    ST_READY     = 2'd2,   // Address and data known
    ST_COMMITTED = 2'd3    // Waiting for the store buffer
  } entry_state_e;

  // Byte mask of an access at lane 0
  function automatic strb_t size_strb(mem_size_e size);
    strb_t strb;
    case (size)
      MEM_B:   strb = strb_t'(8'h01);
      MEM_H:   strb = strb_t'(8'h03);
      MEM_W:   strb = strb_t'(8'h0f);
      MEM_D:   strb = strb_t'(8'hff);
      default: strb = '0;
    endcase
    return strb;
  endfunction

endpackage

//--- source/stq_ring_ctrl.sv
`timescale 1ns/1ps

module stq_ring_ctrl #(
  parameter int STQ_DEPTH = 8
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic                         i_alloc_valid,
  input  logic                         i_commit_valid,
  input  logic                         i_release,

  output logic                         o_alloc_ready,
  output logic [$clog2(STQ_DEPTH)-1:0] o_tail_idx,
  output logic [$clog2(STQ_DEPTH)-1:0] o_commit_idx,
  output logic [$clog2(STQ_DEPTH)-1:0] o_head_idx
);

  localparam int IDX_W = $clog2(STQ_DEPTH);

  logic [IDX_W-1:0] r_tail;
  logic [IDX_W-1:0] r_commit;
  logic [IDX_W-1:0] r_head;
  logic [IDX_W:0]   r_count;    // One extra bit to tell full from empty
  logic             w_full;
  logic             w_alloc_fire;

  assign w_full       = (r_count == (IDX_W+1)'(STQ_DEPTH));
  assign w_alloc_fire = i_alloc_valid & ~w_full;

  assign o_alloc_ready = ~w_full;
  assign o_tail_idx    = r_tail;
  assign o_commit_idx  = r_commit;
  assign o_head_idx    = r_head;

  // ==================================================
  // Pointers
  // ==================================================
  // Depth is a power of two, so the pointers wrap on their own
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail   <= '0;
      r_commit <= '0;
      r_head   <= '0;
    end else begin
      if (w_alloc_fire) begin
        r_tail <= r_tail + 1'b1;
      end
      if (i_commit_valid) begin
        r_commit <= r_commit + 1'b1;
      end
      if (i_release) begin
        r_head <= r_head + 1'b1;
      end
    end
  end

  // ==================================================
  // Occupancy
  // ==================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= '0;
    end else begin
      case ({w_alloc_fire, i_release})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;   // None or both
      endcase
    end
  end

endmodule

//--- source/stq_top.sv
`timescale 1ns/1ps

module stq_top #(
  parameter int STQ_DEPTH = 8
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic                         i_alloc_valid,
  output logic                         o_alloc_ready,
  output logic [$clog2(STQ_DEPTH)-1:0] o_alloc_idx,

  input  logic                         i_upd_valid,
  input  logic [$clog2(STQ_DEPTH)-1:0] i_upd_idx,
  input  stq_pkg::paddr_t              i_upd_paddr,
  input  stq_pkg::mem_size_e           i_upd_size,
  input  stq_pkg::data_t               i_upd_data,

  input  logic                         i_commit_valid,

  input  logic                         i_ld_valid,
  input  stq_pkg::paddr_t              i_ld_paddr,
  input  stq_pkg::mem_size_e           i_ld_size,
  input  logic [$clog2(STQ_DEPTH)-1:0] i_ld_age_idx,
  output logic                         o_fwd_valid,
  output stq_pkg::strb_t               o_fwd_strb,
  output stq_pkg::data_t               o_fwd_data,

  output logic                         o_sb_valid,
  output stq_pkg::paddr_t              o_sb_paddr,
  output stq_pkg::strb_t               o_sb_strb,
  output stq_pkg::data_t               o_sb_data,
  input  logic                         i_sb_ready
);

  import stq_pkg::*;

  localparam int IDX_W = $clog2(STQ_DEPTH);

  logic [IDX_W-1:0] w_tail_idx;
  logic [IDX_W-1:0] w_commit_idx;
  logic [IDX_W-1:0] w_head_idx;
  logic             w_alloc_fire;
  logic             w_release;
  entry_state_e     w_state [STQ_DEPTH];
  paddr_t           w_paddr [STQ_DEPTH];
  mem_size_e        w_size  [STQ_DEPTH];
  data_t            w_data  [STQ_DEPTH];

  assign w_alloc_fire = i_alloc_valid & o_alloc_ready;
  assign o_alloc_idx  = w_tail_idx;   // New entry is the tail

  stq_ring_ctrl #(.STQ_DEPTH(STQ_DEPTH)) u_ring_ctrl (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_alloc_valid  (i_alloc_valid),
    .i_commit_valid (i_commit_valid),
    .i_release      (w_release),
    .o_alloc_ready  (o_alloc_ready),
    .o_tail_idx     (w_tail_idx),
    .o_commit_idx   (w_commit_idx),
    .o_head_idx     (w_head_idx)
  );

  stq_entry_array #(.STQ_DEPTH(STQ_DEPTH)) u_entry_array (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_alloc_fire   (w_alloc_fire),
    .i_tail_idx     (w_tail_idx),
    .i_commit_valid (i_commit_valid),
    .i_commit_idx   (w_commit_idx),
    .i_release      (w_release),
    .i_head_idx     (w_head_idx),
    .i_upd_valid    (i_upd_valid),
    .i_upd_idx      (i_upd_idx),
    .i_upd_paddr    (i_upd_paddr),
    .i_upd_size     (i_upd_size),
    .i_upd_data     (i_upd_data),
    .o_state        (w_state),
    .o_paddr        (w_paddr),
    .o_size         (w_size),
    .o_data         (w_data)
  );

  // Combinational lookup beside the drain path
  stq_fwd_check #(.STQ_DEPTH(STQ_DEPTH)) u_fwd_check (
    .i_ld_valid     (i_ld_valid),
    .i_ld_paddr     (i_ld_paddr),
    .i_ld_size      (i_ld_size),
    .i_ld_age_idx   (i_ld_age_idx),
    .i_head_idx     (w_head_idx),
    .i_state        (w_state),
    .i_paddr        (w_paddr),
    .i_size         (w_size),
    .i_data         (w_data),
    .o_fwd_valid    (o_fwd_valid),
    .o_fwd_strb     (o_fwd_strb),
    .o_fwd_data     (o_fwd_data)
  );

  stq_drain #(.STQ_DEPTH(STQ_DEPTH)) u_drain (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_head_idx     (w_head_idx),
    .i_state        (w_state),
    .i_paddr        (w_paddr),
    .i_size         (w_size),
    .i_data         (w_data),
    .i_sb_ready     (i_sb_ready),
    .o_release      (w_release),
    .o_sb_valid     (o_sb_valid),
    .o_sb_paddr     (o_sb_paddr),
    .o_sb_strb      (o_sb_strb),
    .o_sb_data      (o_sb_data)
  );

endmodule

//--- test/stq_checker.sv
`timescale 1ns/1ps

module stq_checker #(
  parameter int STQ_DEPTH = 8
) (
  input logic                         i_clk,
  input logic                         i_reset_n,
  input logic                         i_alloc_valid,
  input logic                         i_alloc_ready,
  input logic [$clog2(STQ_DEPTH)-1:0] i_alloc_idx,
  input logic                         i_commit_valid,
  input stq_pkg::entry_state_e        i_commit_state,
  input logic                         i_sb_valid,
  input logic                         i_sb_ready,
  input stq_pkg::paddr_t              i_sb_paddr,
  input stq_pkg::strb_t               i_sb_strb,
  input stq_pkg::data_t               i_sb_data
);

  import stq_pkg::*;

  // ==================================================
  // Store buffer request held under back-pressure
  // ==================================================
  a_sb_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_sb_valid && !i_sb_ready |=> i_sb_valid && $stable(i_sb_paddr) &&
                                  $stable(i_sb_strb) && $stable(i_sb_data))
    else $error("Store buffer request dropped or changed before i_sb_ready");

  a_commit_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> i_commit_state == ST_READY)
    else $error("Commit of an entry that is not ready");

  // Tail must not move on a refused allocation
  a_alloc_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc_valid && !i_alloc_ready |=> $stable(i_alloc_idx))
    else $error("Allocation taken while the queue was full");

endmodule

bind stq_top stq_checker #(.STQ_DEPTH(STQ_DEPTH)) u_checker (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_alloc_valid  (i_alloc_valid),
  .i_alloc_ready  (o_alloc_ready),
  .i_alloc_idx    (o_alloc_idx),
  .i_commit_valid (i_commit_valid),
  .i_commit_state (w_state[w_commit_idx]),
  .i_sb_valid     (o_sb_valid),
  .i_sb_ready     (i_sb_ready),
  .i_sb_paddr     (o_sb_paddr),
  .i_sb_strb      (o_sb_strb),
  .i_sb_data      (o_sb_data)
);

//--- test/stq_tb.sv
`timescale 1ns/1ps

module stq_tb;

  import stq_pkg::*;

  localparam int STQ_DEPTH      = 8;
  localparam int IDX_W          = $clog2(STQ_DEPTH);
  localparam int DRAIN_WAIT     = 8;
  localparam int TIMEOUT_CYCLES = 2000;   // Tests take about 200 cycles

  logic             i_clk = 1'b0;
  logic             i_reset_n;
  logic             i_alloc_valid;
  logic             o_alloc_ready;
  logic [IDX_W-1:0] o_alloc_idx;
  logic             i_upd_valid;
  logic [IDX_W-1:0] i_upd_idx;
  paddr_t           i_upd_paddr;
  mem_size_e        i_upd_size;
  data_t            i_upd_data;
  logic             i_commit_valid;
  logic             i_ld_valid;
  paddr_t           i_ld_paddr;
  mem_size_e        i_ld_size;
  logic [IDX_W-1:0] i_ld_age_idx;
  logic             o_fwd_valid;
  strb_t            o_fwd_strb;
  data_t            o_fwd_data;
  logic             o_sb_valid;
  paddr_t           o_sb_paddr;
  strb_t            o_sb_strb;
  data_t            o_sb_data;
  logic             i_sb_ready;

  // Reference copy of each entry and the requests expected in commit order
  paddr_t           mdl_paddr [STQ_DEPTH];
  mem_size_e        mdl_size  [STQ_DEPTH];
  data_t            mdl_data  [STQ_DEPTH];
  paddr_t           exp_paddr [$];
  strb_t            exp_strb  [$];
  data_t            exp_data  [$];
  logic [IDX_W-1:0] tb_tail = '0;
  logic [IDX_W-1:0] tb_commit = '0;
  logic [IDX_W-1:0] fwd_idx0;
  logic [IDX_W-1:0] fwd_idx1;
  logic [31:0]      rng_state = 32'ha9ca;
  int               cycle_cnt = 0;
  int               val_errs = 0;
  int               other_errs = 0;

  stq_top #(.STQ_DEPTH(STQ_DEPTH)) stq_top_i (.*);

  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  // ==================================================
  // Reference rules and random data
  // ==================================================
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic strb_t lane_strb(mem_size_e size, logic [2:0] off);
    int nbytes;
    nbytes = 1 << int'(size);
    return strb_t'(((1 << nbytes) - 1) << off);
  endfunction

  function automatic data_t lane_bits(strb_t strb);   // Byte mask widened to bits
    data_t bits;
    for (int b = 0; b < STRB_W; b++) begin
      bits[b*8 +: 8] = {8{strb[b]}};
    end
    return bits;
  endfunction

  task automatic check_logic(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_idx(string name, logic [IDX_W-1:0] got, logic [IDX_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_paddr(string name, paddr_t got, paddr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_strb(string name, strb_t got, strb_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  // ==================================================
  // Bus actions
  // ==================================================
  task automatic tick();
    @(posedge i_clk);
    #1;
  endtask

  task automatic alloc_one(output logic [IDX_W-1:0] idx);
    check_logic("o_alloc_ready", o_alloc_ready, 1'b1);
    check_idx("o_alloc_idx", o_alloc_idx, tb_tail);
    idx = tb_tail;
    i_alloc_valid = 1'b1;
    tick();
    i_alloc_valid = 1'b0;
    tb_tail++;
  endtask

  task automatic fill_one(logic [IDX_W-1:0] idx, paddr_t addr, mem_size_e size, data_t data);
    mdl_paddr[idx] = addr;
    mdl_size[idx]  = size;
    mdl_data[idx]  = data;
    i_upd_valid = 1'b1;
    i_upd_idx   = idx;
    i_upd_paddr = addr;
    i_upd_size  = size;
    i_upd_data  = data;
    tick();
    i_upd_valid = 1'b0;
  endtask

  task automatic random_fill(logic [IDX_W-1:0] idx);
    mem_size_e size;
    paddr_t    addr;
    int        nbytes;
    size   = mem_size_e'(lcg_next() % 4);
    nbytes = 1 << int'(size);
    addr   = lcg_next() & ~paddr_t'(nbytes - 1);   // Naturally aligned
    fill_one(idx, addr, size, {lcg_next(), lcg_next()});
  endtask

  task automatic commit_one();
    logic [2:0] off;
    off = mdl_paddr[tb_commit][2:0];
    exp_paddr.push_back({mdl_paddr[tb_commit][PADDR_W-1:3], 3'b000});
    exp_strb.push_back(lane_strb(mdl_size[tb_commit], off));
    exp_data.push_back(mdl_data[tb_commit] << (8 * int'(off)));
    i_commit_valid = 1'b1;
    tick();
    i_commit_valid = 1'b0;
    tb_commit++;
  endtask

  task automatic wait_sb_valid();
    int n;
    n = 0;
    while (!o_sb_valid && n < DRAIN_WAIT) begin
      tick();
      n++;
    end
  endtask

  task automatic drain_one();
    wait_sb_valid();
    if (!o_sb_valid) begin
      $display("No store buffer request within %0d cycles", DRAIN_WAIT);
      other_errs++;
    end else if (exp_paddr.size() == 0) begin
      $display("Store buffer request with no committed store pending");
      other_errs++;
    end else begin
      check_paddr("o_sb_paddr", o_sb_paddr, exp_paddr.pop_front());
      check_strb("o_sb_strb", o_sb_strb, exp_strb.pop_front());
      check_data("o_sb_data", o_sb_data, exp_data.pop_front());
      i_sb_ready = 1'b1;
      tick();
      i_sb_ready = 1'b0;
    end
  endtask

  task automatic drain_all();
    while (exp_paddr.size() > 0) begin
      drain_one();
    end
  endtask

  task automatic load_check(paddr_t addr, mem_size_e size, logic [IDX_W-1:0] age,
                            strb_t exp_s, data_t exp_d);
    i_ld_valid   = 1'b1;
    i_ld_paddr   = addr;
    i_ld_size    = size;
    i_ld_age_idx = age;
    #1;   // Combinational answer settles
    check_logic("o_fwd_valid", o_fwd_valid, |exp_s);
    check_strb("o_fwd_strb", o_fwd_strb, exp_s);
    check_data("o_fwd_data", o_fwd_data & lane_bits(exp_s), exp_d);
    i_ld_valid = 1'b0;
    tick();
  endtask

  // ==================================================
  // Tests
  // ==================================================
  task automatic test_alloc_full();
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] first;
    first = tb_tail;
    for (int i = 0; i < STQ_DEPTH; i++) begin
      alloc_one(idx);
    end
    check_logic("o_alloc_ready", o_alloc_ready, 1'b0);
    i_alloc_valid = 1'b1;   // Refused while full
    tick();
    i_alloc_valid = 1'b0;
    check_logic("o_alloc_ready", o_alloc_ready, 1'b0);
    check_idx("o_alloc_idx", o_alloc_idx, tb_tail);
    for (int i = 0; i < STQ_DEPTH; i++) begin
      random_fill(first + IDX_W'(i));
    end
    for (int i = 0; i < STQ_DEPTH; i++) begin
      commit_one();
    end
    drain_one();
    check_logic("o_alloc_ready", o_alloc_ready, 1'b1);
    drain_all();
  endtask

  task automatic test_drain_order();
    logic [IDX_W-1:0] idx;
    paddr_t           base;
    base = lcg_next() & ~paddr_t'(7);
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < STRB_W; off += (1 << s)) begin
        alloc_one(idx);
        fill_one(idx, base | paddr_t'(off), mem_size_e'(s), {lcg_next(), lcg_next()});
        commit_one();
        if (exp_paddr.size() == 4) begin
          drain_all();
        end
      end
    end
    drain_all();
  endtask

  task automatic test_backpressure();
    logic [IDX_W-1:0] idx_a;
    logic [IDX_W-1:0] idx_b;
    alloc_one(idx_a);
    random_fill(idx_a);
    commit_one();
    alloc_one(idx_b);
    random_fill(idx_b);   // Filled, left uncommitted
    wait_sb_valid();
    repeat (5) begin
      check_logic("o_sb_valid", o_sb_valid, 1'b1);
      check_paddr("o_sb_paddr", o_sb_paddr, exp_paddr[0]);
      check_strb("o_sb_strb", o_sb_strb, exp_strb[0]);
      check_data("o_sb_data", o_sb_data, exp_data[0]);
      tick();
    end
    drain_one();
    repeat (6) begin
      check_logic("o_sb_valid", o_sb_valid, 1'b0);
      tick();
    end
    commit_one();
    drain_one();
  endtask

  task automatic test_fwd_youngest();
    alloc_one(fwd_idx0);
    fill_one(fwd_idx0, 32'h0000_1000, MEM_W, 64'h0000_0000_4433_2211);
    alloc_one(fwd_idx1);
    fill_one(fwd_idx1, 32'h0000_1002, MEM_H, 64'h0000_0000_0000_bbaa);
    load_check(32'h0000_1000, MEM_D, tb_tail, 8'h0f, 64'h0000_0000_bbaa_2211);
    load_check(32'h0000_1003, MEM_B, tb_tail, 8'h08, 64'h0000_0000_bb00_0000);
  endtask

  task automatic test_fwd_excluded();
    load_check(32'h0000_1000, MEM_D, fwd_idx1, 8'h0f, 64'h0000_0000_4433_2211);
    load_check(32'h0000_1000, MEM_D, fwd_idx0, 8'h00, 64'h0);   // Both younger
    load_check(32'h0000_1008, MEM_D, tb_tail, 8'h00, 64'h0);
    commit_one();
    commit_one();
    drain_all();
  endtask

  initial begin
    i_reset_n      = 1'b0;
    i_alloc_valid  = 1'b0;
    i_upd_valid    = 1'b0;
    i_upd_idx      = '0;
    i_upd_paddr    = '0;
    i_upd_size     = MEM_B;
    i_upd_data     = '0;
    i_commit_valid = 1'b0;
    i_ld_valid     = 1'b0;
    i_ld_paddr     = '0;
    i_ld_size      = MEM_B;
    i_ld_age_idx   = '0;
    i_sb_ready     = 1'b0;
    repeat (3) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    tick();
    test_alloc_full();
    test_drain_order();
    test_backpressure();
    test_fwd_youngest();
    test_fwd_excluded();
    $display("Value errors: %0d, other errors: %0d", val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
